// ==== hw/conv_ctrl_pkg.sv ====
// convolution controller package with field widths, the configuration map and FSM codes
`default_nettype none

package conv_ctrl_pkg;

  // -------------------------------------------------------------------
  // widths
  // -------------------------------------------------------------------

  // the parameter FIFO carries one address byte above one data byte
  localparam int cfg_addr_width = 8;
  localparam int cfg_data_width = 8;
  localparam int fifo_word_width = cfg_addr_width + cfg_data_width;

  // maximum addresses of the weight and ifmap banks
  // the tracker widens its fill counters by one bit so that max+1 fits
  localparam int buf_addr_width = 16;

  // loop counter, oc1 count and the total inner-loop count
  localparam int count_width = 32;

  // -------------------------------------------------------------------
  // configuration address map
  // -------------------------------------------------------------------

  // each field is little-endian, so the lowest slot holds the low byte
  localparam int cfg_weight_max_lo = 0;
  localparam int cfg_ifmap_max_lo = 2;
  localparam int cfg_oc1_lo = 4;

  // total is ic1*fy*fx*oy0*ox0 and tile is oy0*ox0
  localparam int cfg_total_lo = 8;
  localparam int cfg_tile_lo = 12;

  // a word at this address ends the configuration stream
  localparam int cfg_last_addr = 16;
  localparam int cfg_slots = 16;

  // -------------------------------------------------------------------
  // sequencer FSM state codes
  // -------------------------------------------------------------------

  localparam int state_width = 2;
  localparam logic [state_width-1:0] st_wait = 2'd0;
  localparam logic [state_width-1:0] st_fill = 2'd1;
  localparam logic [state_width-1:0] st_inner = 2'd2;
  localparam logic [state_width-1:0] st_next = 2'd3;

endpackage

`default_nettype wire

// ==== hw/conv_config_loader.sv ====
// configuration loader that dequeues address/data words and holds the layer fields
`default_nettype none

module conv_config_loader import conv_ctrl_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [fifo_word_width-1:0] params_fifo_dout,
  input  logic                       params_fifo_empty_n,
  output logic                       params_fifo_deq,
  output logic                       config_en,
  output logic                       cfg_done,
  output logic [buf_addr_width-1:0]  weight_max,
  output logic [buf_addr_width-1:0]  ifmap_max,
  output logic [count_width-1:0]     oc1_count,
  output logic [count_width-1:0]     total_count,
  output logic [count_width-1:0]     tile_count
);

  // fields of the word at the head of the FIFO
  logic [cfg_addr_width-1:0] cfg_addr;
  logic [cfg_data_width-1:0] cfg_data;

  // one byte register per configuration slot
  logic [cfg_data_width-1:0] cfg_r [cfg_slots];

  logic slot_wr;
  logic marker_seen;

  assign cfg_addr = params_fifo_dout[fifo_word_width-1:cfg_data_width];
  assign cfg_data = params_fifo_dout[cfg_data_width-1:0];

  // words are taken whenever the FIFO has data, until the end marker
  // has gone by, after which the FIFO is left alone
  assign params_fifo_deq = params_fifo_empty_n && !cfg_done;

  assign marker_seen = params_fifo_deq && (cfg_addr == cfg_addr_width'(cfg_last_addr));

  // addresses outside the slot range, other than the marker, are dropped
  assign slot_wr = params_fifo_deq && (cfg_addr < cfg_addr_width'(cfg_slots));

  // -------------------------------------------------------------------
  // configuration byte storage
  // -------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (slot_wr) begin
      cfg_r[cfg_addr[$clog2(cfg_slots)-1:0]] <= cfg_data;
    end
  end

  // -------------------------------------------------------------------
  // completion
  // -------------------------------------------------------------------

  // cfg_done stays high for the rest of the run; config_en is the single
  // cycle in which it first rises
  always_ff @(posedge clk) begin
    if (rst_n) begin
      cfg_done <= 1'b0;
      config_en <= 1'b0;
    end else begin
      config_en <= marker_seen;
      if (marker_seen) begin
        cfg_done <= 1'b1;
      end
    end
  end

  // fields are assembled from their byte slots, low byte first
  assign weight_max = {cfg_r[cfg_weight_max_lo + 1], cfg_r[cfg_weight_max_lo]};
  assign ifmap_max = {cfg_r[cfg_ifmap_max_lo + 1], cfg_r[cfg_ifmap_max_lo]};
  assign oc1_count = {cfg_r[cfg_oc1_lo + 3], cfg_r[cfg_oc1_lo + 2],
                      cfg_r[cfg_oc1_lo + 1], cfg_r[cfg_oc1_lo]};
  assign total_count = {cfg_r[cfg_total_lo + 3], cfg_r[cfg_total_lo + 2],
                        cfg_r[cfg_total_lo + 1], cfg_r[cfg_total_lo]};
  assign tile_count = {cfg_r[cfg_tile_lo + 3], cfg_r[cfg_tile_lo + 2],
                       cfg_r[cfg_tile_lo + 1], cfg_r[cfg_tile_lo]};

endmodule

`default_nettype wire

// ==== hw/conv_buffer_tracker.sv ====
// double buffer tracker counting weight and ifmap fill and ofmap drain, with full/empty flags
`default_nettype none

module conv_buffer_tracker import conv_ctrl_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      cfg_done,
  input  logic [buf_addr_width-1:0] weight_max,
  input  logic [buf_addr_width-1:0] ifmap_max,
  input  logic [count_width-1:0]    tile_count,
  input  logic                      weight_wen,
  input  logic                      ifmap_wen,
  input  logic                      ofmap_wb_ren,
  input  logic                      weight_switch_banks,
  input  logic                      ifmap_switch_banks,
  input  logic                      ofmap_switch_banks,
  output logic                      weight_db_full_n,
  output logic                      ifmap_db_full_n,
  output logic                      ofmap_db_empty_n
);

  // fill counters are one bit wider so they can hold max+1
  logic [buf_addr_width:0] weight_fill_r;
  logic [buf_addr_width:0] ifmap_fill_r;

  // ofmap entries still to be read out of the accumulation bank
  logic [count_width-1:0] ofmap_drain_r;

  logic weight_accept;
  logic ifmap_accept;
  logic drain_pending;

  // -------------------------------------------------------------------
  // weight and ifmap fill
  // -------------------------------------------------------------------

  // a bank accepts writes only once the layer is configured and while
  // its counter has not passed the last address
  assign weight_db_full_n = cfg_done && (weight_fill_r <= {1'b0, weight_max});
  assign ifmap_db_full_n = cfg_done && (ifmap_fill_r <= {1'b0, ifmap_max});

  // writes seen while the flag is low are simply not counted
  assign weight_accept = weight_wen && weight_db_full_n;
  assign ifmap_accept = ifmap_wen && ifmap_db_full_n;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      weight_fill_r <= '0;
    end else if (weight_switch_banks) begin
      // the filled bank moves to the array side and the other one is empty
      weight_fill_r <= '0;
    end else if (weight_accept) begin
      weight_fill_r <= weight_fill_r + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      ifmap_fill_r <= '0;
    end else if (ifmap_switch_banks) begin
      ifmap_fill_r <= '0;
    end else if (ifmap_accept) begin
      ifmap_fill_r <= ifmap_fill_r + 1'b1;
    end
  end

  // -------------------------------------------------------------------
  // ofmap drain
  // -------------------------------------------------------------------

  assign drain_pending = (ofmap_drain_r != '0);

  // an ofmap switch hands a finished tile of oy0*ox0 entries to the
  // reader, and each read while entries remain takes one away
  always_ff @(posedge clk) begin
    if (rst_n) begin
      ofmap_drain_r <= '0;
    end else if (ofmap_switch_banks) begin
      ofmap_drain_r <= tile_count;
    end else if (ofmap_wb_ren && drain_pending) begin
      ofmap_drain_r <= ofmap_drain_r - 1'b1;
    end
  end

  // the empty flag is held low through the switch cycle so the reader
  // never sees the old bank marked as readable
  always_ff @(posedge clk) begin
    if (rst_n) begin
      ofmap_db_empty_n <= 1'b0;
    end else begin
      ofmap_db_empty_n <= drain_pending && !ofmap_switch_banks;
    end
  end

endmodule

`default_nettype wire

// ==== hw/conv_loop_sequencer.sv ====
// loop sequencer FSM running the initial fill, the inner-loop enables and the oc1 bank switches
`default_nettype none

module conv_loop_sequencer import conv_ctrl_pkg::*; #(
  parameter int array_height = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cfg_done,
  input  logic [count_width-1:0] oc1_count,
  input  logic [count_width-1:0] total_count,
  input  logic [count_width-1:0] tile_count,
  input  logic                   weight_db_full_n,
  input  logic                   ifmap_db_full_n,
  input  logic                   ofmap_db_empty_n,
  output logic                   weight_switch_banks,
  output logic                   ifmap_switch_banks,
  output logic                   ofmap_switch_banks,
  output logic                   weight_ren,
  output logic                   ifmap_ren,
  output logic                   systolic_array_en,
  output logic                   ofmap_wen
);

  // a weight read burst loads one row per cycle into the array
  localparam logic [count_width-1:0] weight_burst = count_width'(array_height);

  // the array plus its output skew delays results by twice its height
  localparam logic [count_width-1:0] pipe_depth = count_width'(2 * array_height);

  logic [state_width-1:0] state_r;

  // loop_r counts every cycle of the inner pass
  logic [count_width-1:0] loop_r;

  // ic1_r counts finished oy0*ox0 tiles, that is ic1*fy*fx positions
  logic [count_width-1:0] ic1_r;

  // oc1_r selects which output-channel block the pass is computing
  logic [count_width-1:0] oc1_r;

  logic [count_width-1:0] ic1_base;
  logic                   tile_end;
  logic                   oc1_last;
  logic                   pass_done;

  // cycle at which the current tile of partial sums started
  assign ic1_base = ic1_r * tile_count;
  assign tile_end = (loop_r == ic1_base + tile_count - 1'b1);

  // the ifmap tile is reused across all oc1 blocks and is only replaced
  // after the last one
  assign oc1_last = (oc1_r == oc1_count - 1'b1);

  // the pass may end only when the next weight tile is in, the array has
  // drained, the previous ofmap tile has been read out and every cycle
  // of the schedule has run; on the last oc1 block the next ifmap tile
  // must also be present
  assign pass_done = !weight_db_full_n && !systolic_array_en && !ofmap_db_empty_n &&
                     (loop_r >= total_count) && (!oc1_last || !ifmap_db_full_n);

  // -------------------------------------------------------------------
  // FSM, loop counters and bank switches
  // -------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_r <= st_wait;
      loop_r <= '0;
      ic1_r <= '0;
      oc1_r <= '0;
      weight_switch_banks <= 1'b0;
      ifmap_switch_banks <= 1'b0;
      ofmap_switch_banks <= 1'b0;
    end else begin
      // switch strobes last one cycle unless set again below
      weight_switch_banks <= 1'b0;
      ifmap_switch_banks <= 1'b0;
      ofmap_switch_banks <= 1'b0;

      case (state_r)
        st_wait: begin
          // nothing moves until the loader has the whole layer
          if (cfg_done) begin
            state_r <= st_fill;
          end
        end

        st_fill: begin
          // first weight and ifmap tiles go in before any compute starts
          if (!weight_db_full_n && !ifmap_db_full_n) begin
            weight_switch_banks <= 1'b1;
            ifmap_switch_banks <= 1'b1;
            loop_r <= '0;
            ic1_r <= '0;
            state_r <= st_inner;
          end
        end

        st_inner: begin
          loop_r <= loop_r + 1'b1;
          if (tile_end) begin
            ic1_r <= ic1_r + 1'b1;
          end
          if (pass_done) begin
            state_r <= st_next;
          end
        end

        st_next: begin
          // one ofmap block is complete, so swap weights and ofmap banks
          weight_switch_banks <= 1'b1;
          ofmap_switch_banks <= 1'b1;
          if (oc1_last) begin
            ifmap_switch_banks <= 1'b1;
            oc1_r <= '0;
          end else begin
            oc1_r <= oc1_r + 1'b1;
          end
          loop_r <= '0;
          ic1_r <= '0;
          state_r <= st_inner;
        end

        default: begin
          state_r <= st_wait;
        end
      endcase
    end
  end

  // -------------------------------------------------------------------
  // inner-loop read and enable windows
  // -------------------------------------------------------------------

  // every window is decoded from loop_r and registered, so each output
  // rises one cycle after its count is reached
  always_ff @(posedge clk) begin
    if (rst_n) begin
      weight_ren <= 1'b0;
      ifmap_ren <= 1'b0;
      systolic_array_en <= 1'b0;
      ofmap_wen <= 1'b0;
    end else if (state_r == st_inner) begin
      // a burst of array_height weight reads at the start of each tile
      weight_ren <= (loop_r >= ic1_base) && (loop_r < ic1_base + weight_burst) &&
                    (ic1_base < total_count);
      // ifmap reads trail the first weight read by one cycle
      ifmap_ren <= (loop_r >= count_width'(1)) && (loop_r <= total_count);
      // the array runs once operands arrive and keeps going to flush
      systolic_array_en <= (loop_r >= count_width'(2)) &&
                           (loop_r <= total_count + pipe_depth);
      // results leave the skew registers pipe_depth cycles late
      ofmap_wen <= (loop_r > pipe_depth) && (loop_r <= total_count + pipe_depth);
    end else begin
      weight_ren <= 1'b0;
      ifmap_ren <= 1'b0;
      systolic_array_en <= 1'b0;
      ofmap_wen <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== hw/conv_controller.sv ====
// convolution controller top joining the config loader, buffer tracker and loop sequencer
`default_nettype none

module conv_controller import conv_ctrl_pkg::*; #(
  parameter int array_height = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [fifo_word_width-1:0] params_fifo_dout,
  input  logic                       params_fifo_empty_n,
  output logic                       params_fifo_deq,
  output logic                       config_en,
  input  logic                       weight_wen,
  input  logic                       ifmap_wen,
  input  logic                       ofmap_wb_ren,
  output logic                       weight_db_full_n,
  output logic                       ifmap_db_full_n,
  output logic                       ofmap_db_empty_n,
  output logic                       weight_switch_banks,
  output logic                       ifmap_switch_banks,
  output logic                       ofmap_switch_banks,
  output logic                       weight_ren,
  output logic                       ifmap_ren,
  output logic                       systolic_array_en,
  output logic                       ofmap_wen
);

  // -------------------------------------------------------------------
  // layer configuration shared by the tracker and the sequencer
  // -------------------------------------------------------------------

  logic                      cfg_done;
  logic [buf_addr_width-1:0] weight_max;
  logic [buf_addr_width-1:0] ifmap_max;
  logic [count_width-1:0]    oc1_count;
  logic [count_width-1:0]    total_count;
  logic [count_width-1:0]    tile_count;

  // reads the parameter FIFO until the end marker
  conv_config_loader u_loader (
    .clk                 (clk),
    .rst_n               (rst_n),
    .params_fifo_dout    (params_fifo_dout),
    .params_fifo_empty_n (params_fifo_empty_n),
    .params_fifo_deq     (params_fifo_deq),
    .config_en           (config_en),
    .cfg_done            (cfg_done),
    .weight_max          (weight_max),
    .ifmap_max           (ifmap_max),
    .oc1_count           (oc1_count),
    .total_count         (total_count),
    .tile_count          (tile_count)
  );

  // turns the switch strobes back into fill and drain state
  conv_buffer_tracker u_tracker (
    .clk                 (clk),
    .rst_n               (rst_n),
    .cfg_done            (cfg_done),
    .weight_max          (weight_max),
    .ifmap_max           (ifmap_max),
    .tile_count          (tile_count),
    .weight_wen          (weight_wen),
    .ifmap_wen           (ifmap_wen),
    .ofmap_wb_ren        (ofmap_wb_ren),
    .weight_switch_banks (weight_switch_banks),
    .ifmap_switch_banks  (ifmap_switch_banks),
    .ofmap_switch_banks  (ofmap_switch_banks),
    .weight_db_full_n    (weight_db_full_n),
    .ifmap_db_full_n     (ifmap_db_full_n),
    .ofmap_db_empty_n    (ofmap_db_empty_n)
  );

  // waits on the flags and schedules the array
  conv_loop_sequencer #(
    .array_height (array_height)
  ) u_sequencer (
    .clk                 (clk),
    .rst_n               (rst_n),
    .cfg_done            (cfg_done),
    .oc1_count           (oc1_count),
    .total_count         (total_count),
    .tile_count          (tile_count),
    .weight_db_full_n    (weight_db_full_n),
    .ifmap_db_full_n     (ifmap_db_full_n),
    .ofmap_db_empty_n    (ofmap_db_empty_n),
    .weight_switch_banks (weight_switch_banks),
    .ifmap_switch_banks  (ifmap_switch_banks),
    .ofmap_switch_banks  (ofmap_switch_banks),
    .weight_ren          (weight_ren),
    .ifmap_ren           (ifmap_ren),
    .systolic_array_en   (systolic_array_en),
    .ofmap_wen           (ofmap_wen)
  );

endmodule

`default_nettype wire

// ==== tests/conv_controller_checker.sv ====
// assertion checker for FIFO dequeue, switch pulse width and the single config strobe
`default_nettype none

module conv_controller_checker (
  input logic clk,
  input logic rst_n,
  input logic params_fifo_empty_n,
  input logic params_fifo_deq,
  input logic config_en,
  input logic weight_switch_banks,
  input logic ifmap_switch_banks,
  input logic ofmap_switch_banks
);
  timeunit 1ns;
  timeprecision 100ps;

  // remembers that the configuration strobe has already gone by
  logic config_seen;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      config_seen <= 1'b0;
    end else if (config_en) begin
      config_seen <= 1'b1;
    end
  end

  // -------------------------------------------------------------------
  // properties
  // -------------------------------------------------------------------

  // a word can only be taken when the FIFO offers one
  deq_needs_data: assert property (@(posedge clk) disable iff (rst_n)
    !params_fifo_empty_n |-> !params_fifo_deq)
    else $error("params_fifo_deq high while params_fifo_empty_n is low");

  // every bank switch is a single-cycle strobe
  weight_switch_pulse: assert property (@(posedge clk) disable iff (rst_n)
    weight_switch_banks |=> !weight_switch_banks)
    else $error("weight_switch_banks held longer than one cycle");

  ifmap_switch_pulse: assert property (@(posedge clk) disable iff (rst_n)
    ifmap_switch_banks |=> !ifmap_switch_banks)
    else $error("ifmap_switch_banks held longer than one cycle");

  ofmap_switch_pulse: assert property (@(posedge clk) disable iff (rst_n)
    ofmap_switch_banks |=> !ofmap_switch_banks)
    else $error("ofmap_switch_banks held longer than one cycle");

  // the layer is configured once, the strobe never comes back
  config_once: assert property (@(posedge clk) disable iff (rst_n)
    config_seen |-> !config_en)
    else $error("config_en rose a second time");

endmodule

bind conv_controller conv_controller_checker u_checker (
  .clk                 (clk),
  .rst_n               (rst_n),
  .params_fifo_empty_n (params_fifo_empty_n),
  .params_fifo_deq     (params_fifo_deq),
  .config_en           (config_en),
  .weight_switch_banks (weight_switch_banks),
  .ifmap_switch_banks  (ifmap_switch_banks),
  .ofmap_switch_banks  (ofmap_switch_banks)
);

`default_nettype wire

// ==== tests/conv_controller_tb.sv ====
// random-stimulus testbench for the convolution controller with a reference model and watchdog
`default_nettype none

module conv_controller_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int array_height = 4;
  localparam int n_words = 18;
  localparam int marker_addr = 16;
  // each ifmap tile is reused over oc1 passes, and three ifmap rounds are run
  localparam int rounds = 3;

  logic        clk = 1'b0;
  logic        rst_n = 1'b1;
  logic [15:0] params_fifo_dout = '0;
  logic        params_fifo_empty_n = 1'b0;
  logic        weight_wen = 1'b0;
  logic        ifmap_wen = 1'b0;
  logic        ofmap_wb_ren = 1'b0;
  logic        params_fifo_deq;
  logic        config_en;
  logic        weight_db_full_n;
  logic        ifmap_db_full_n;
  logic        ofmap_db_empty_n;
  logic        weight_switch_banks;
  logic        ifmap_switch_banks;
  logic        ofmap_switch_banks;
  logic        weight_ren;
  logic        ifmap_ren;
  logic        systolic_array_en;
  logic        ofmap_wen;

  // layer configuration picked at time zero
  int weight_max;
  int ifmap_max;
  int oc1;
  int tile;
  int total;
  int limit;
  logic [15:0] cfg_words [n_words];
  int word_idx = 0;
  logic [31:0] rng_state = 32'd75307;

  // reference model state
  logic cfg_seen = 1'b0;
  logic marker_prev = 1'b0;
  logic exp_empty_n = 1'b0;
  logic run_done = 1'b0;
  int w_fill = 0;
  int i_fill = 0;
  int drain = 0;
  int pass_idx = 0;
  int full_wait = 0;
  int n_iren = 0;
  int n_owen = 0;
  int n_saen = 0;
  int n_wren = 0;
  int n_reads = 0;

  conv_controller #(.array_height(array_height)) uut (.*);

  always #4 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  // -------------------------------------------------------------------
  // configuration, reset and end of run
  // -------------------------------------------------------------------

  initial begin
    logic [7:0] cfg_bytes [16];
    int slot;
    weight_max = 3 + next_rand() % 8;
    ifmap_max = 3 + next_rand() % 8;
    oc1 = 2 + next_rand() % 2;
    // tiles stay longer than a weight burst so bursts never overlap
    tile = array_height + 4 + next_rand() % 5;
    total = tile * (1 + next_rand() % 3);
    for (int i = 0; i < 2; i++) begin
      cfg_bytes[0 + i] = 8'(weight_max >> (8 * i));
      cfg_bytes[2 + i] = 8'(ifmap_max >> (8 * i));
    end
    for (int i = 0; i < 4; i++) begin
      cfg_bytes[4 + i] = 8'(oc1 >> (8 * i));
      cfg_bytes[8 + i] = 8'(total >> (8 * i));
      cfg_bytes[12 + i] = 8'(tile >> (8 * i));
    end
    // slot words in order, a stray address in the middle and the marker last
    slot = 0;
    for (int i = 0; i < n_words - 1; i++) begin
      if (i == 8) begin
        cfg_words[i] = {8'h40, 8'(next_rand())};
      end else begin
        cfg_words[i] = {8'(slot), cfg_bytes[slot]};
        slot++;
      end
    end
    cfg_words[n_words - 1] = {8'(marker_addr), 8'h00};
    limit = oc1 * (total + 4 * array_height + 64) * rounds + 2000;
    repeat (2) @(posedge clk);
    rst_n <= 1'b0;
    wait (run_done);
    @(posedge clk);
    $display("TESTBENCH PASSED");
    $finish;
  end

  initial begin
    #1;
    repeat (limit) @(posedge clk);
    $display("watchdog expired before all passes were completed");
    $display("TESTBENCH FAILED");
    $fatal(1);
  end

  // -------------------------------------------------------------------
  // stimulus: FIFO stream with gaps, bank writers and the drain reader
  // -------------------------------------------------------------------

  always @(posedge clk) begin : stimulus
    logic [31:0] r;
    r = next_rand();
    if (!rst_n) begin
      if (params_fifo_deq) begin
        word_idx = word_idx + 1;
      end
      if (word_idx >= n_words) begin
        // after the marker the FIFO keeps offering a word that must stay put
        params_fifo_empty_n <= 1'b1;
        params_fifo_dout <= cfg_words[n_words - 1];
      end else if (r[1:0] != 2'b00) begin
        params_fifo_empty_n <= 1'b1;
        params_fifo_dout <= cfg_words[word_idx];
      end else begin
        params_fifo_empty_n <= 1'b0;
        params_fifo_dout <= r[31:16];
      end
      weight_wen <= r[2];
      ifmap_wen <= r[3];
      ofmap_wb_ren <= ofmap_db_empty_n && (r[5:4] != 2'b00);
    end
  end

  // -------------------------------------------------------------------
  // reference model and checks
  // -------------------------------------------------------------------

  always @(posedge clk) begin : model
    logic exp_wfull;
    logic exp_ifull;
    logic marker_now;
    if (!rst_n) begin
      // a bank takes writes until it holds max+1 entries
      exp_wfull = cfg_seen && (w_fill <= weight_max);
      exp_ifull = cfg_seen && (i_fill <= ifmap_max);
      marker_now = params_fifo_deq && (params_fifo_dout[15:8] == marker_addr);
      check_value("params_fifo_deq", params_fifo_empty_n && !cfg_seen, params_fifo_deq);
      check_value("config_en", marker_prev, config_en);
      check_value("weight_db_full_n", exp_wfull, weight_db_full_n);
      check_value("ifmap_db_full_n", exp_ifull, ifmap_db_full_n);
      check_value("ofmap_db_empty_n", exp_empty_n, ofmap_db_empty_n);
      if (!cfg_seen) begin
        check_value("sequencer outputs before marker", 0,
                    {weight_switch_banks, ifmap_switch_banks, ofmap_switch_banks,
                     weight_ren, ifmap_ren, systolic_array_en, ofmap_wen});
      end
      if (ifmap_switch_banks || ofmap_switch_banks) begin
        check_value("weight_switch_banks", 1, weight_switch_banks);
      end
      // switch 0 closes the fill, switch k closes inner pass k
      if (weight_switch_banks) begin
        check_value("ofmap_switch_banks", pass_idx > 0, ofmap_switch_banks);
        check_value("ifmap_switch_banks", (pass_idx == 0) || (pass_idx % oc1 == 0),
                    ifmap_switch_banks);
        if (pass_idx == 0) begin
          check_value("fill cycles with both banks full", 1, full_wait);
        end
        check_value("ifmap_ren cycles", (pass_idx > 0) ? total : 0, n_iren);
        check_value("ofmap_wen cycles", (pass_idx > 0) ? total : 0, n_owen);
        check_value("systolic_array_en cycles",
                    (pass_idx > 0) ? total + 2 * array_height - 1 : 0, n_saen);
        check_value("weight_ren cycles",
                    (pass_idx > 0) ? array_height * (total / tile) : 0, n_wren);
        // the previous tile has to be read out before a pass may end
        if (pass_idx > 1) begin
          check_value("ofmap reads per tile", tile, n_reads);
        end
        n_iren = 0;
        n_owen = 0;
        n_saen = 0;
        n_wren = 0;
        n_reads = 0;
        if (pass_idx == oc1 * rounds) begin
          run_done = 1'b1;
        end
        pass_idx++;
      end
      n_iren += ifmap_ren;
      n_owen += ofmap_wen;
      n_saen += systolic_array_en;
      n_wren += weight_ren;
      if (pass_idx == 0 && cfg_seen && !exp_wfull && !exp_ifull) begin
        full_wait++;
      end
      // bank fill and ofmap drain bookkeeping
      if (weight_switch_banks) begin
        w_fill = 0;
      end else if (weight_wen && exp_wfull) begin
        w_fill++;
      end
      if (ifmap_switch_banks) begin
        i_fill = 0;
      end else if (ifmap_wen && exp_ifull) begin
        i_fill++;
      end
      exp_empty_n = (drain > 0) && !ofmap_switch_banks;
      if (ofmap_switch_banks) begin
        drain = tile;
      end else if (ofmap_wb_ren && drain > 0) begin
        drain--;
        n_reads++;
      end
      if (marker_now) begin
        cfg_seen = 1'b1;
      end
      marker_prev = marker_now;
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
hw/conv_ctrl_pkg.sv
hw/conv_config_loader.sv
hw/conv_buffer_tracker.sv
hw/conv_loop_sequencer.sv
hw/conv_controller.sv
tests/conv_controller_checker.sv
tests/conv_controller_tb.sv
